/* issuePkg.sv */
`default_nettype none

package issuePkg;

    localparam int NUM_UOPS = 2;
    localparam int NUM_PORTS = 2;
    localparam int IQ_SIZE = 8;
    localparam int IQ_IDX_BITS = $clog2(IQ_SIZE);
    localparam int TAG_BITS = 6;
    localparam int SQN_BITS = 7;
    localparam int MUL_LATENCY = 3;
    localparam int NUM_RF_READS = 2 * NUM_PORTS;

    typedef logic [TAG_BITS-1:0] Tag;
    typedef logic [SQN_BITS-1:0] SqN;

    typedef enum logic [1:0] {
        FU_INT,
        FU_MUL
    } FuncUnit;

    // Function-unit masks for the queue and port parameters
    localparam int FUS_INT = 1 << FU_INT;
    localparam int FUS_INT_MUL = (1 << FU_INT) | (1 << FU_MUL);

    // MUL returns the low 32 bits of the product
    typedef enum logic [2:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLL,
        SRL,
        MUL
    } Opcode;

    typedef struct packed {
        logic [9:0] pad;
        Tag tag;
    } OperandReg;

    // Second operand is a register tag or a sign-extended immediate, selected by immB
    typedef union packed {
        logic [15:0] imm;
        OperandReg src;
    } OperandB;

    typedef struct packed {
        logic valid;
        logic [NUM_PORTS-1:0] validIQ;
        FuncUnit fu;
        Opcode opcode;
        SqN sqN;
        Tag tagDst;
        Tag tagA;
        logic availA;
        OperandB srcB;
        logic immB;
        logic availB;
    } R_UOp;

    typedef struct packed {
        logic valid;
        FuncUnit fu;
        Opcode opcode;
        SqN sqN;
        Tag tagDst;
        Tag tagA;
        OperandB srcB;
        logic immB;
    } IS_UOp;

    typedef struct packed {
        logic valid;
        Tag tagDst;
        SqN sqN;
        logic [31:0] result;
    } RES_UOp;

    typedef struct packed {
        logic taken;
        SqN sqN;
    } BranchProv;

    // Sequence numbers wrap, so age is the sign of the difference
    function automatic logic isYounger(SqN a, SqN b);
        return $signed(a - b) > 0;
    endfunction

    function automatic logic hasFu(int fus, FuncUnit fu);
        return ((fus >> fu) & 1) != 0;
    endfunction

endpackage

`default_nettype wire

/* PriorityEncoder.sv */
`default_nettype none

module PriorityEncoder #(
    parameter int WIDTH = 8
) (
    input  logic [WIDTH-1:0]         request,
    output logic [$clog2(WIDTH)-1:0] idx,
    output logic                     valid
);

    // Scan from the top so the lowest set bit is the last one written
    always_comb begin
        idx = '0;
        valid = 1'b0;
        for (int i = WIDTH - 1; i >= 0; i--) begin
            if (request[i]) begin
                idx = ($clog2(WIDTH))'(i);
                valid = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* IssueQueue.sv */
`default_nettype none

module IssueQueue #(
    parameter int PORT_IDX = 0,
    parameter int FUS = 1
) (
    input  logic                          clk,
    input  logic                          rst,
    input  issuePkg::R_UOp                uops[issuePkg::NUM_UOPS],
    output logic [issuePkg::NUM_UOPS-1:0] stall,
    input  issuePkg::RES_UOp              resultUOps[issuePkg::NUM_PORTS],
    input  issuePkg::IS_UOp               issueUOps[issuePkg::NUM_PORTS],
    input  issuePkg::BranchProv           branch,
    output issuePkg::IS_UOp               issueUOp
);

    typedef struct packed {
        issuePkg::FuncUnit fu;
        issuePkg::Opcode opcode;
        issuePkg::SqN sqN;
        issuePkg::Tag tagDst;
        issuePkg::Tag tagA;
        logic availA;
        issuePkg::OperandB srcB;
        logic immB;
        logic availB;
    } QueueEntry;

    // Entry 0 is the oldest
    QueueEntry entries[issuePkg::IQ_SIZE];
    QueueEntry nextEntries[issuePkg::IQ_SIZE];
    logic [issuePkg::IQ_IDX_BITS:0] insertIndex;
    logic [issuePkg::IQ_IDX_BITS:0] nextInsert;
    issuePkg::IS_UOp nextIssue;

    // Bit 0 set means the writeback slot of an ALU op picked now is taken
    logic [issuePkg::MUL_LATENCY-1:0] reservedWBs;
    logic [issuePkg::MUL_LATENCY-1:0] wbReserve;

    logic [1:0] newAvail[issuePkg::IQ_SIZE];
    logic [issuePkg::IQ_SIZE-1:0] candidates;
    logic [issuePkg::IQ_IDX_BITS-1:0] selIdx;
    logic selValid;
    logic doIssue;

    // Result buses plus ALU ops issuing now, whose value is ready next cycle
    function automatic logic isWoken(issuePkg::Tag tag);
        logic hit;
        hit = 1'b0;
        for (int j = 0; j < issuePkg::NUM_PORTS; j++) begin
            if (resultUOps[j].valid && resultUOps[j].tagDst == tag)
                hit = 1'b1;
            if (issueUOps[j].valid && issueUOps[j].fu == issuePkg::FU_INT &&
                    issueUOps[j].tagDst == tag)
                hit = 1'b1;
        end
        return hit;
    endfunction

    always_comb begin
        for (int i = 0; i < issuePkg::IQ_SIZE; i++) begin
            newAvail[i][0] = isWoken(entries[i].tagA);
            newAvail[i][1] = isWoken(entries[i].srcB.src.tag);
            candidates[i] = (i < insertIndex) &&
                (entries[i].availA | newAvail[i][0]) &&
                (entries[i].availB | newAvail[i][1]) &&
                !(entries[i].fu == issuePkg::FU_INT && reservedWBs[0]);
        end
    end

    PriorityEncoder #(
        .WIDTH(issuePkg::IQ_SIZE)
    ) selEncoder (
        .request(candidates),
        .idx(selIdx),
        .valid(selValid)
    );

    assign doIssue = selValid && !branch.taken;

    always_comb begin
        wbReserve = reservedWBs;
        if (doIssue && entries[selIdx].fu == issuePkg::FU_MUL)
            wbReserve[issuePkg::MUL_LATENCY-1] = 1'b1;
    end

    always_comb begin
        logic [issuePkg::IQ_IDX_BITS:0] slot;
        logic blocked;
        QueueEntry enq;

        for (int i = 0; i < issuePkg::IQ_SIZE; i++) begin
            nextEntries[i] = entries[i];
            nextEntries[i].availA = entries[i].availA | newAvail[i][0];
            nextEntries[i].availB = entries[i].availB | newAvail[i][1];
        end
        nextInsert = insertIndex;
        nextIssue = '0;
        stall = '0;
        slot = insertIndex;
        blocked = 1'b0;
        enq = '0;

        if (branch.taken) begin
            // Keep everything up to the last entry that is not younger than the branch
            nextInsert = '0;
            for (int i = 0; i < issuePkg::IQ_SIZE; i++) begin
                if (i < insertIndex && !issuePkg::isYounger(entries[i].sqN, branch.sqN))
                    nextInsert = (issuePkg::IQ_IDX_BITS + 1)'(i + 1);
            end
        end else if (selValid) begin
            nextIssue.valid = 1'b1;
            nextIssue.fu = entries[selIdx].fu;
            nextIssue.opcode = entries[selIdx].opcode;
            nextIssue.sqN = entries[selIdx].sqN;
            nextIssue.tagDst = entries[selIdx].tagDst;
            nextIssue.tagA = entries[selIdx].tagA;
            nextIssue.srcB = entries[selIdx].srcB;
            nextIssue.immB = entries[selIdx].immB;
            // Close the gap left by the issued entry
            for (int i = 0; i < issuePkg::IQ_SIZE - 1; i++) begin
                if (i >= selIdx)
                    nextEntries[i] = nextEntries[i + 1];
            end
            nextInsert = insertIndex - 1'b1;
        end

        // Ops for this queue go in slot order, a stalled op stalls the later ones
        for (int i = 0; i < issuePkg::NUM_UOPS; i++) begin
            if (uops[i].valid && uops[i].validIQ[PORT_IDX] && issuePkg::hasFu(FUS, uops[i].fu)) begin
                if (blocked || branch.taken ||
                        slot == (issuePkg::IQ_IDX_BITS + 1)'(issuePkg::IQ_SIZE)) begin
                    stall[i] = 1'b1;
                    blocked = 1'b1;
                end else begin
                    enq.fu = uops[i].fu;
                    enq.opcode = uops[i].opcode;
                    enq.sqN = uops[i].sqN;
                    enq.tagDst = uops[i].tagDst;
                    enq.tagA = uops[i].tagA;
                    enq.srcB = uops[i].srcB;
                    enq.immB = uops[i].immB;
                    // Catch a broadcast that happens while the op is being written
                    enq.availA = uops[i].availA | isWoken(uops[i].tagA);
                    enq.availB = uops[i].availB | uops[i].immB |
                        isWoken(uops[i].srcB.src.tag);
                    nextEntries[nextInsert[issuePkg::IQ_IDX_BITS-1:0]] = enq;
                    nextInsert = nextInsert + 1'b1;
                    slot = slot + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        entries <= nextEntries;
        if (rst) begin
            insertIndex <= '0;
            reservedWBs <= '0;
            issueUOp.valid <= 1'b0;
        end else begin
            insertIndex <= nextInsert;
            reservedWBs <= wbReserve >> 1;
            issueUOp <= nextIssue;
        end
    end

endmodule

`default_nettype wire

/* PhysRegFile.sv */
`default_nettype none

module PhysRegFile (
    input  logic             clk,
    input  logic             rst,
    input  issuePkg::Tag     readTags[issuePkg::NUM_RF_READS],
    output logic [31:0]      readData[issuePkg::NUM_RF_READS],
    input  issuePkg::RES_UOp results[issuePkg::NUM_PORTS]
);

    logic [31:0] regs[2 ** issuePkg::TAG_BITS];

    // One write port per result bus, tags never collide
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 2 ** issuePkg::TAG_BITS; i++)
                regs[i] <= '0;
        end else begin
            for (int j = 0; j < issuePkg::NUM_PORTS; j++) begin
                if (results[j].valid)
                    regs[results[j].tagDst] <= results[j].result;
            end
        end
    end

    always_comb begin
        for (int k = 0; k < issuePkg::NUM_RF_READS; k++)
            readData[k] = regs[readTags[k]];
    end

endmodule

`default_nettype wire

/* ExecPort.sv */
`default_nettype none

module ExecPort #(
    parameter int FUS = 1
) (
    input  logic                clk,
    input  logic                rst,
    input  issuePkg::IS_UOp     issueUOp,
    output issuePkg::Tag        readTags[2],
    input  logic [31:0]         readData[2],
    input  issuePkg::RES_UOp    results[issuePkg::NUM_PORTS],
    input  issuePkg::BranchProv branch,
    output issuePkg::RES_UOp    result
);

    logic [31:0] opA;
    logic [31:0] opB;
    logic [31:0] aluValue;
    logic issueFlushed;
    logic aluIssue;
    logic mulIssue;

    issuePkg::RES_UOp aluRes;
    issuePkg::RES_UOp mulPipe[issuePkg::MUL_LATENCY];
    issuePkg::RES_UOp wbSel;

    assign readTags[0] = issueUOp.tagA;
    assign readTags[1] = issueUOp.srcB.src.tag;

    // A result on a bus this cycle is not in the register file yet
    always_comb begin
        opA = readData[0];
        opB = readData[1];
        for (int j = 0; j < issuePkg::NUM_PORTS; j++) begin
            if (results[j].valid && results[j].tagDst == issueUOp.tagA)
                opA = results[j].result;
            if (results[j].valid && results[j].tagDst == issueUOp.srcB.src.tag)
                opB = results[j].result;
        end
        if (issueUOp.immB)
            opB = {{16{issueUOp.srcB.imm[15]}}, issueUOp.srcB.imm};
    end

    always_comb begin
        case (issueUOp.opcode)
            issuePkg::ADD: aluValue = opA + opB;
            issuePkg::SUB: aluValue = opA - opB;
            issuePkg::AND: aluValue = opA & opB;
            issuePkg::OR:  aluValue = opA | opB;
            issuePkg::XOR: aluValue = opA ^ opB;
            issuePkg::SLL: aluValue = opA << opB[4:0];
            issuePkg::SRL: aluValue = opA >> opB[4:0];
            default:       aluValue = '0;
        endcase
    end

    assign issueFlushed = branch.taken && issuePkg::isYounger(issueUOp.sqN, branch.sqN);
    assign aluIssue = issueUOp.valid && issueUOp.fu == issuePkg::FU_INT && !issueFlushed;
    assign mulIssue = issueUOp.valid && issueUOp.fu == issuePkg::FU_MUL &&
        issuePkg::hasFu(FUS, issuePkg::FU_MUL) && !issueFlushed;

    always_ff @(posedge clk) begin
        aluRes.tagDst <= issueUOp.tagDst;
        aluRes.sqN <= issueUOp.sqN;
        aluRes.result <= aluValue;
        if (rst)
            aluRes.valid <= 1'b0;
        else
            aluRes.valid <= aluIssue;
    end

    // Product is formed in the first stage, later stages carry tag and sqN to writeback
    always_ff @(posedge clk) begin
        mulPipe[0].tagDst <= issueUOp.tagDst;
        mulPipe[0].sqN <= issueUOp.sqN;
        mulPipe[0].result <= opA * opB;
        for (int k = 1; k < issuePkg::MUL_LATENCY; k++) begin
            mulPipe[k].tagDst <= mulPipe[k - 1].tagDst;
            mulPipe[k].sqN <= mulPipe[k - 1].sqN;
            mulPipe[k].result <= mulPipe[k - 1].result;
        end
        if (rst) begin
            for (int k = 0; k < issuePkg::MUL_LATENCY; k++)
                mulPipe[k].valid <= 1'b0;
        end else begin
            mulPipe[0].valid <= mulIssue;
            for (int k = 1; k < issuePkg::MUL_LATENCY; k++) begin
                mulPipe[k].valid <= mulPipe[k - 1].valid &&
                    !(branch.taken && issuePkg::isYounger(mulPipe[k - 1].sqN, branch.sqN));
            end
        end
    end

    // The queue's writeback reservation keeps both paths from being valid together
    assign wbSel = aluRes.valid ? aluRes : mulPipe[issuePkg::MUL_LATENCY-1];

    always_comb begin
        result = wbSel;
        result.valid = wbSel.valid &&
            !(branch.taken && issuePkg::isYounger(wbSel.sqN, branch.sqN));
    end

endmodule

`default_nettype wire

/* IssueSubsystem.sv */
`default_nettype none

module IssueSubsystem (
    input  logic                          clk,
    input  logic                          rst,
    input  issuePkg::R_UOp                uops[issuePkg::NUM_UOPS],
    input  issuePkg::BranchProv           branch,
    output logic [issuePkg::NUM_UOPS-1:0] stall,
    output issuePkg::RES_UOp              results[issuePkg::NUM_PORTS]
);

    logic [issuePkg::NUM_UOPS-1:0] queueStall[issuePkg::NUM_PORTS];
    issuePkg::IS_UOp issueBus[issuePkg::NUM_PORTS];
    issuePkg::Tag rfReadTags[issuePkg::NUM_RF_READS];
    logic [31:0] rfReadData[issuePkg::NUM_RF_READS];

    // Port 0 takes ALU ops and multiplies, the other ports ALU ops only
    for (genvar p = 0; p < issuePkg::NUM_PORTS; p++) begin : portSlice
        issuePkg::Tag portTags[2];
        logic [31:0] portData[2];

        IssueQueue #(
            .PORT_IDX(p),
            .FUS(p == 0 ? issuePkg::FUS_INT_MUL : issuePkg::FUS_INT)
        ) issueQueue (
            .clk(clk),
            .rst(rst),
            .uops(uops),
            .stall(queueStall[p]),
            .resultUOps(results),
            .issueUOps(issueBus),
            .branch(branch),
            .issueUOp(issueBus[p])
        );

        ExecPort #(
            .FUS(p == 0 ? issuePkg::FUS_INT_MUL : issuePkg::FUS_INT)
        ) execPort (
            .clk(clk),
            .rst(rst),
            .issueUOp(issueBus[p]),
            .readTags(portTags),
            .readData(portData),
            .results(results),
            .branch(branch),
            .result(results[p])
        );

        assign rfReadTags[2 * p] = portTags[0];
        assign rfReadTags[2 * p + 1] = portTags[1];
        assign portData[0] = rfReadData[2 * p];
        assign portData[1] = rfReadData[2 * p + 1];
    end

    PhysRegFile physRegFile (
        .clk(clk),
        .rst(rst),
        .readTags(rfReadTags),
        .readData(rfReadData),
        .results(results)
    );

    always_comb begin
        stall = '0;
        for (int p = 0; p < issuePkg::NUM_PORTS; p++)
            stall = stall | queueStall[p];
    end

endmodule

`default_nettype wire

/* IssueSubsystemTb.sv */
`default_nettype none

module IssueSubsystemTb;

    logic clk;
    logic rst;
    issuePkg::R_UOp uops[issuePkg::NUM_UOPS];
    issuePkg::BranchProv branch;
    logic [issuePkg::NUM_UOPS-1:0] stall;
    issuePkg::RES_UOp results[issuePkg::NUM_PORTS];

    // Renamer and reference model state, indexed by destination tag
    int seed;
    int nextTag;
    int nextSqN;
    int outstanding;
    int flushSqN;
    bit stallSeen;
    string testName;
    logic [31:0] modelReg[2 ** issuePkg::TAG_BITS];
    bit pending[2 ** issuePkg::TAG_BITS];
    bit seen[2 ** issuePkg::TAG_BITS];
    issuePkg::Tag srcATag[2 ** issuePkg::TAG_BITS];
    issuePkg::Tag srcBTag[2 ** issuePkg::TAG_BITS];
    int sqnOf[2 ** issuePkg::TAG_BITS];
    issuePkg::Tag usable[$];

    IssueSubsystem i_IssueSubsystem (
        .clk(clk),
        .rst(rst),
        .uops(uops),
        .branch(branch),
        .stall(stall),
        .results(results)
    );

    always #20 clk = ~clk;

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic checkValue(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (expected !== actual)
            abortRun($sformatf("Mismatch in %s, %s: expected 0x%08h, actual 0x%08h",
                testName, what, expected, actual));
    endtask

    function automatic logic [31:0] refValue(input issuePkg::Opcode op, input logic [31:0] a,
                                             input logic [31:0] b);
        case (op)
            issuePkg::ADD: return a + b;
            issuePkg::SUB: return a - b;
            issuePkg::AND: return a & b;
            issuePkg::OR:  return a | b;
            issuePkg::XOR: return a ^ b;
            issuePkg::SLL: return a << b[4:0];
            issuePkg::SRL: return a >> b[4:0];
            issuePkg::MUL: return a * b;
            default:       return 32'h0;
        endcase
    endfunction

    function automatic int randBelow(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    // Random defined tag, optionally only one whose result is already back
    function automatic issuePkg::Tag pickSrc(input bit onlySeen);
        issuePkg::Tag pool[$];
        foreach (usable[i]) begin
            if (!onlySeen || seen[usable[i]])
                pool.push_back(usable[i]);
        end
        return pool[randBelow(pool.size())];
    endfunction

    task automatic makeOp(input issuePkg::Opcode op, input int port, input issuePkg::Tag a,
                          input bit useImm, input issuePkg::Tag b, output issuePkg::R_UOp u);
        logic [31:0] bValue;
        int t;
        t = nextTag;
        nextTag++;
        u = '0;
        u.valid = 1'b1;
        u.validIQ[port] = 1'b1;
        u.fu = (op == issuePkg::MUL) ? issuePkg::FU_MUL : issuePkg::FU_INT;
        u.opcode = op;
        u.sqN = issuePkg::SqN'(nextSqN);
        u.tagDst = issuePkg::Tag'(t);
        u.tagA = a;
        u.availA = seen[a];
        if (useImm) begin
            u.srcB.imm = 16'($random(seed));
            u.immB = 1'b1;
            u.availB = 1'b1;
            bValue = {{16{u.srcB.imm[15]}}, u.srcB.imm};
            srcBTag[t] = '0;
        end else begin
            u.srcB.src.tag = b;
            u.availB = seen[b];
            bValue = modelReg[b];
            srcBTag[t] = b;
        end
        modelReg[t] = refValue(op, modelReg[a], bValue);
        srcATag[t] = a;
        sqnOf[t] = nextSqN;
        pending[t] = 1'b1;
        outstanding++;
        usable.push_back(issuePkg::Tag'(t));
        nextSqN++;
    endtask

    task automatic randomAluOp(input int port, input issuePkg::Tag a, input bit onlySeen,
                               output issuePkg::R_UOp u);
        issuePkg::Opcode op;
        bit useImm;
        issuePkg::Tag b;
        op = issuePkg::Opcode'(randBelow(7));
        useImm = randBelow(2) == 1;
        b = pickSrc(onlySeen);
        makeOp(op, port, a, useImm, b, u);
    endtask

    // A stalled op stays on its slot unchanged until the DUT takes it
    task automatic dispatchPair(input issuePkg::R_UOp first, input issuePkg::R_UOp second);
        int cycles;
        logic [1:0] taken;
        logic [issuePkg::NUM_UOPS-1:0] stallNow;
        cycles = 0;
        uops[0] = first;
        uops[1] = second;
        taken = {!second.valid, !first.valid};
        while (taken != 2'b11) begin
            @(negedge clk);
            stallNow = stall;
            if ((stallNow & ~taken) != 0)
                stallSeen = 1'b1;
            @(posedge clk);
            #5;
            for (int i = 0; i < issuePkg::NUM_UOPS; i++) begin
                if (!taken[i] && !stallNow[i]) begin
                    uops[i].valid = 1'b0;
                    taken[i] = 1'b1;
                end
            end
            cycles++;
            if (cycles > 100)
                abortRun($sformatf("Dispatch in %s was stalled for 100 cycles", testName));
        end
    endtask

    task automatic waitDrain();
        int cycles;
        cycles = 0;
        while (outstanding != 0) begin
            @(posedge clk);
            #5;
            cycles++;
            if (cycles > 200)
                abortRun($sformatf("%0d results never arrived in %s", outstanding, testName));
        end
    endtask

    // Results are registered, so the falling edge sees them settled
    always @(negedge clk) begin
        issuePkg::Tag t;
        logic [issuePkg::NUM_PORTS-1:0] hit;
        if (!rst) begin
            hit = '0;
            for (int p = 0; p < issuePkg::NUM_PORTS; p++) begin
                if (results[p].valid) begin
                    t = results[p].tagDst;
                    if (results[p].sqN > flushSqN)
                        abortRun($sformatf("Port %0d returned sqN %0d after a flush at sqN %0d",
                            p, results[p].sqN, flushSqN));
                    if (!pending[t])
                        abortRun($sformatf("Port %0d returned tag %0d, not expected or a repeat",
                            p, t));
                    if (!seen[srcATag[t]] || !seen[srcBTag[t]])
                        abortRun($sformatf("Tag %0d came back before one of its sources", t));
                    checkValue($sformatf("tag %0d value", t), modelReg[t], results[p].result);
                    checkValue($sformatf("tag %0d sqN", t), sqnOf[t], 32'(results[p].sqN));
                    pending[t] = 1'b0;
                    outstanding--;
                    hit[p] = 1'b1;
                end
            end
            for (int p = 0; p < issuePkg::NUM_PORTS; p++) begin
                if (hit[p])
                    seen[results[p].tagDst] = 1'b1;
            end
        end
    end

    initial begin
        issuePkg::R_UOp a;
        issuePkg::R_UOp b;
        issuePkg::R_UOp p;
        issuePkg::Tag chain;
        issuePkg::Tag held;

        clk = 1'b0;
        rst = 1'b1;
        uops[0] = '0;
        uops[1] = '0;
        branch = '0;
        seed = 55;
        nextTag = 1;
        nextSqN = 0;
        outstanding = 0;
        flushSqN = 1000;
        stallSeen = 1'b0;
        foreach (modelReg[i]) begin
            modelReg[i] = '0;
            pending[i] = 1'b0;
            seen[i] = 1'b0;
        end
        // Tag 0 is never written and reads as zero
        seen[0] = 1'b1;
        usable.push_back('0);
        repeat (4) @(posedge clk);
        #5;
        rst = 1'b0;

        testName = "independent ops";
        repeat (2) begin
            repeat (2) begin
                randomAluOp(randBelow(2), pickSrc(1), 1, a);
                randomAluOp(randBelow(2), pickSrc(1), 1, b);
                dispatchPair(a, b);
            end
            waitDrain();
        end

        // Each op feeds the next one on the other port
        testName = "dependent chains";
        chain = pickSrc(1);
        repeat (4) begin
            randomAluOp(0, chain, 0, a);
            randomAluOp(1, a.tagDst, 0, b);
            chain = b.tagDst;
            dispatchPair(a, b);
        end
        waitDrain();

        testName = "multiplies";
        repeat (4) begin
            makeOp(issuePkg::MUL, 0, pickSrc(0), 0, pickSrc(0), a);
            if (randBelow(2) == 1)
                makeOp(issuePkg::MUL, 0, a.tagDst, 0, pickSrc(0), b);
            else
                randomAluOp(randBelow(2), a.tagDst, 0, b);
            dispatchPair(a, b);
        end
        waitDrain();

        // Queue 1 fills with ops waiting on a producer that is sent last
        testName = "back-pressure";
        stallSeen = 1'b0;
        randomAluOp(0, pickSrc(1), 1, p);
        repeat (4) begin
            randomAluOp(1, p.tagDst, 1, a);
            randomAluOp(1, p.tagDst, 1, b);
            dispatchPair(a, b);
        end
        randomAluOp(1, pickSrc(1), 1, b);
        dispatchPair(p, b);
        if (!stallSeen)
            abortRun("Stall did not rise with a full issue queue");
        waitDrain();

        testName = "branch flush";
        makeOp(issuePkg::MUL, 0, pickSrc(1), 0, pickSrc(1), a);
        randomAluOp(1, a.tagDst, 1, b);
        dispatchPair(a, b);
        randomAluOp(0, b.tagDst, 0, a);
        randomAluOp(1, pickSrc(1), 1, b);
        dispatchPair(a, b);
        flushSqN = sqnOf[b.tagDst];
        // Younger ops wait on an older op still behind the multiply, so they issue unless flushed
        held = a.tagDst;
        makeOp(issuePkg::MUL, 0, held, 1, '0, a);
        randomAluOp(1, held, 1, b);
        dispatchPair(a, b);
        randomAluOp(0, held, 1, a);
        randomAluOp(1, held, 1, b);
        dispatchPair(a, b);
        branch.taken = 1'b1;
        branch.sqN = issuePkg::SqN'(flushSqN);
        for (int t = 0; t < 2 ** issuePkg::TAG_BITS; t++) begin
            if (pending[t] && sqnOf[t] > flushSqN) begin
                pending[t] = 1'b0;
                outstanding--;
            end
        end
        @(posedge clk);
        #5;
        branch = '0;
        waitDrain();
        repeat (10) @(posedge clk);

        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
issuePkg.sv
PriorityEncoder.sv
IssueQueue.sv
PhysRegFile.sv
ExecPort.sv
IssueSubsystem.sv
IssueSubsystemTb.sv

/* run.sh */
#!/bin/sh
# Compile and run the issue subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module IssueSubsystemTb \
    -Mdir obj_dir -o simv -f build.f
if [ $? -ne 0 ]; then
    echo "Compilation failed"
    exit 1
fi

./obj_dir/simv > sim.log 2>&1
status=$?
cat sim.log

if grep -q "Something failed" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "Simulator exited with status $status"
    exit 1
fi
if ! grep -q "Everything OK" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
exit 0
